// File: hdl/tracker_pkg.sv
/*
 * Tracker package
 * Widths, bus structs, divider states and tuning constants shared by
 * the camera tracking pipeline and the servo drivers.
 */
package tracker_pkg;

    // ==================================================================
    // Widths
    // ==================================================================
    typedef logic [11:0] pix_t;
    typedef logic [9:0]  col_t;
    typedef logic [8:0]  row_t;
    typedef logic [15:0] frame_cnt_t;
    typedef logic [21:0] sum_t;
    typedef logic [12:0] hits_t;
    typedef logic [11:0] pwm_cnt_t;

    // ==================================================================
    // Buses between stages
    // ==================================================================
    typedef struct packed {
        pix_t pix;
        col_t col;
        row_t row;
        logic valid;
    } pixel_bus_s;

    typedef struct packed {
        col_t col;
        row_t row;
        logic hit;
    } hit_s;

    typedef struct packed {
        col_t col;
        row_t row;
        logic found;
    } centroid_s;

    typedef struct packed {
        col_t col;
        row_t row;
    } aim_s;

    // Centroid divider FSM
    typedef enum logic [1:0] {
        div_idle,
        div_divide,
        div_done
    } div_state_e;

    // ==================================================================
    // Tuning
    // ==================================================================
    // Small frame keeps simulation short
    localparam int FRAME_COLS = 64;
    localparam int FRAME_ROWS = 48;

    localparam pix_t HIT_THRESHOLD = 12'd2048;
    localparam int   LOST_FRAMES   = 3;

    // Servo timing in pixel clocks
    localparam int SERVO_PERIOD = 2048;
    localparam int SERVO_MIN    = 512;

    // Aim point with no target
    localparam int CENTER_COL = 32;
    localparam int CENTER_ROW = 24;

endpackage

// File: hdl/frame_capture.sv
/*
 * Frame capture
 * Registers the D5M pixel, line-valid and frame-valid signals, gates
 * capture with start and stop strobes and tracks column, row and frame.
 */
`timescale 1ns/1ps

module frame_capture (
    input  logic                    reset,
    input  logic                    D5M_PIXLCLK,
    input  tracker_pkg::pix_t       d5m_d,
    input  logic                    d5m_lval,
    input  logic                    d5m_fval,
    input  logic                    capture_start,
    input  logic                    capture_stop,
    output tracker_pkg::pixel_bus_s pixel,
    output logic                    frame_end,
    output tracker_pkg::frame_cnt_t frame_count
);

    tracker_pkg::pix_t d_q;
    logic              lval_q;
    logic              fval_q;
    logic              lval_d;
    logic              fval_d;
    logic              fval_rise;
    logic              fval_fall;
    logic              line_end;
    logic              capturing;
    logic              start_pending;
    logic              stop_pending;
    logic              in_window;
    tracker_pkg::col_t col_cnt;
    tracker_pkg::row_t row_cnt;

    // Sensor input registers
    always_ff @(posedge D5M_PIXLCLK)
    begin
        d_q <= d5m_d;
    end

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (reset)
        begin
            lval_q <= 1'b0;
            fval_q <= 1'b0;
            lval_d <= 1'b0;
            fval_d <= 1'b0;
        end
        else
        begin
            lval_q <= d5m_lval;
            fval_q <= d5m_fval;
            lval_d <= lval_q;
            fval_d <= fval_q;
        end
    end

    assign fval_rise = fval_q & ~fval_d;
    assign fval_fall = ~fval_q & fval_d;
    assign line_end  = ~lval_q & lval_d;

    // ==================================================================
    // Capture enable
    // ==================================================================
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (reset)
        begin
            capturing     <= 1'b0;
            start_pending <= 1'b0;
            stop_pending  <= 1'b0;
        end
        else
        begin
            // Start takes effect on a frame boundary
            if (fval_rise && start_pending)
            begin
                capturing     <= 1'b1;
                start_pending <= 1'b0;
            end
            // Stop lets the running frame finish
            if (fval_fall && capturing && stop_pending)
            begin
                capturing    <= 1'b0;
                stop_pending <= 1'b0;
            end
            if (capture_start)
            begin
                start_pending <= 1'b1;
                stop_pending  <= 1'b0;
            end
            if (capture_stop)
            begin
                stop_pending  <= 1'b1;
                start_pending <= 1'b0;
            end
        end
    end

    // ==================================================================
    // Position and frame counters
    // ==================================================================
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (reset)
        begin
            col_cnt <= '0;
            row_cnt <= '0;
        end
        else
        begin
            // Column zero while the line is blanked
            if (lval_q)
                col_cnt <= col_cnt + 1'b1;
            else
                col_cnt <= '0;
            if (!fval_q)
                row_cnt <= '0;
            else if (line_end)
                row_cnt <= row_cnt + 1'b1;
        end
    end

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (reset)
        begin
            frame_end   <= 1'b0;
            frame_count <= '0;
        end
        else
        begin
            frame_end <= fval_fall & capturing;
            if (fval_fall && capturing)
                frame_count <= frame_count + 1'b1;
        end
    end

    // Crop anything outside the configured frame
    assign in_window = (col_cnt < tracker_pkg::col_t'(tracker_pkg::FRAME_COLS)) &&
                       (row_cnt < tracker_pkg::row_t'(tracker_pkg::FRAME_ROWS));

    always_comb
    begin
        pixel.pix   = d_q;
        pixel.col   = col_cnt;
        pixel.row   = row_cnt;
        pixel.valid = capturing & fval_q & lval_q & in_window;
    end

endmodule

// File: hdl/object_detect.sv
/*
 * Object detect
 * Marks pixels brighter than the detection threshold and passes the
 * verdict on together with the pixel position.
 */
`timescale 1ns/1ps

module object_detect (
    input  logic                    reset,
    input  logic                    D5M_PIXLCLK,
    input  tracker_pkg::pixel_bus_s pixel,
    output tracker_pkg::hit_s       hit
);

    // Position travels with the verdict
    always_ff @(posedge D5M_PIXLCLK)
    begin
        hit.col <= pixel.col;
        hit.row <= pixel.row;
    end

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (reset)
            hit.hit <= 1'b0;
        else
            hit.hit <= pixel.valid && (pixel.pix > tracker_pkg::HIT_THRESHOLD);
    end

endmodule

// File: hdl/centroid_accum.sv
/*
 * Centroid accumulator
 * Sums the coordinates of marked pixels over a frame and divides both
 * sums by the hit count at frame end to give the mean target position.
 */
`timescale 1ns/1ps

module centroid_accum (
    input  logic                   reset,
    input  logic                   D5M_PIXLCLK,
    input  tracker_pkg::hit_s      hit,
    input  logic                   frame_end,
    output tracker_pkg::centroid_s centroid,
    output logic                   cent_valid
);

    // Partial remainder and quotient of one axis
    typedef struct packed {
        tracker_pkg::hits_t rem;
        tracker_pkg::sum_t  quo;
    } div_reg_s;

    tracker_pkg::div_state_e state;
    tracker_pkg::sum_t       col_sum;
    tracker_pkg::sum_t       row_sum;
    tracker_pkg::hits_t      hit_cnt;
    tracker_pkg::hits_t      divisor;
    div_reg_s                col_div;
    div_reg_s                row_div;
    div_reg_s                col_next;
    div_reg_s                row_next;
    logic [$clog2($bits(tracker_pkg::sum_t))-1:0] step_cnt;

    // One restoring step, dividend bits shift out as quotient bits shift in
    function automatic div_reg_s div_step(div_reg_s cur, tracker_pkg::hits_t den);
        logic [$bits(tracker_pkg::hits_t):0] trial;
        div_reg_s                            nxt;
        trial   = {cur.rem, cur.quo[$bits(tracker_pkg::sum_t)-1]};
        nxt.quo = {cur.quo[$bits(tracker_pkg::sum_t)-2:0], 1'b0};
        if (trial >= {1'b0, den})
        begin
            trial      = trial - {1'b0, den};
            nxt.quo[0] = 1'b1;
        end
        nxt.rem = trial[$bits(tracker_pkg::hits_t)-1:0];
        return nxt;
    endfunction

    assign col_next   = div_step(col_div, divisor);
    assign row_next   = div_step(row_div, divisor);
    assign cent_valid = (state == tracker_pkg::div_done);

    // ==================================================================
    // Per-frame sums
    // ==================================================================
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (reset)
        begin
            col_sum <= '0;
            row_sum <= '0;
            hit_cnt <= '0;
        end
        else if (frame_end && state == tracker_pkg::div_idle)
        begin
            // Sums handed to the divider, next frame starts clean
            col_sum <= '0;
            row_sum <= '0;
            hit_cnt <= '0;
        end
        else if (hit.hit)
        begin
            col_sum <= col_sum + tracker_pkg::sum_t'(hit.col);
            row_sum <= row_sum + tracker_pkg::sum_t'(hit.row);
            hit_cnt <= hit_cnt + 1'b1;
        end
    end

    // ==================================================================
    // Divider
    // ==================================================================
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (state == tracker_pkg::div_idle)
        begin
            divisor  <= hit_cnt;
            col_div  <= '{rem: '0, quo: col_sum};
            row_div  <= '{rem: '0, quo: row_sum};
            step_cnt <= $bits(step_cnt)'($bits(tracker_pkg::sum_t) - 1);
        end
        else if (state == tracker_pkg::div_divide)
        begin
            col_div  <= col_next;
            row_div  <= row_next;
            step_cnt <= step_cnt - 1'b1;
        end
    end

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (reset)
        begin
            state    <= tracker_pkg::div_idle;
            centroid <= '0;
        end
        else
        begin
            case (state)
                tracker_pkg::div_idle:
                begin
                    if (frame_end && hit_cnt == '0)
                    begin
                        // Empty frame, report right away
                        centroid <= '0;
                        state    <= tracker_pkg::div_done;
                    end
                    else if (frame_end)
                        state <= tracker_pkg::div_divide;
                end
                tracker_pkg::div_divide:
                begin
                    if (step_cnt == '0)
                    begin
                        centroid.col   <= tracker_pkg::col_t'(col_next.quo);
                        centroid.row   <= tracker_pkg::row_t'(row_next.quo);
                        centroid.found <= 1'b1;
                        state          <= tracker_pkg::div_done;
                    end
                end
                default:
                    state <= tracker_pkg::div_idle;
            endcase
        end
    end

endmodule

// File: hdl/target_hold.sv
/*
 * Target hold
 * Keeps the last good centroid, counts consecutive empty frames and
 * falls back to the screen center once the target is lost.
 */
`timescale 1ns/1ps

module target_hold (
    input  logic                   reset,
    input  logic                   D5M_PIXLCLK,
    input  tracker_pkg::centroid_s centroid,
    input  logic                   cent_valid,
    output tracker_pkg::aim_s      aim,
    output logic                   on_screen
);

    tracker_pkg::aim_s target;
    logic [$clog2(tracker_pkg::LOST_FRAMES + 1)-1:0] miss_cnt;

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (cent_valid && centroid.found)
        begin
            target.col <= centroid.col;
            target.row <= centroid.row;
        end
    end

    // Miss counter saturates at the loss limit
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (reset)
        begin
            on_screen <= 1'b0;
            miss_cnt  <= '0;
        end
        else if (cent_valid)
        begin
            if (centroid.found)
            begin
                on_screen <= 1'b1;
                miss_cnt  <= '0;
            end
            else if (int'(miss_cnt) != tracker_pkg::LOST_FRAMES)
            begin
                miss_cnt <= miss_cnt + 1'b1;
                if (int'(miss_cnt) == tracker_pkg::LOST_FRAMES - 1)
                    on_screen <= 1'b0;
            end
        end
    end

    always_comb
    begin
        if (on_screen)
            aim = target;
        else
        begin
            aim.col = tracker_pkg::col_t'(tracker_pkg::CENTER_COL);
            aim.row = tracker_pkg::row_t'(tracker_pkg::CENTER_ROW);
        end
    end

endmodule

// File: hdl/servo_pwm.sv
/*
 * Servo PWM
 * One axis of servo drive. The pulse is SERVO_MIN plus the position
 * in pixel clocks, repeated every SERVO_PERIOD clocks.
 */
`timescale 1ns/1ps

module servo_pwm (
    input  logic              reset,
    input  logic              D5M_PIXLCLK,
    input  tracker_pkg::col_t position,
    output logic              pwm
);

    tracker_pkg::pwm_cnt_t period_cnt;
    tracker_pkg::pwm_cnt_t width;

    // Width loaded on the last clock, held for the whole next period
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (reset)
        begin
            period_cnt <= '0;
            width      <= '0;
        end
        else if (period_cnt == tracker_pkg::pwm_cnt_t'(tracker_pkg::SERVO_PERIOD - 1))
        begin
            period_cnt <= '0;
            width      <= tracker_pkg::pwm_cnt_t'(tracker_pkg::SERVO_MIN) +
                          tracker_pkg::pwm_cnt_t'(position);
        end
        else
            period_cnt <= period_cnt + 1'b1;
    end

    assign pwm = (period_cnt < width);

endmodule

// File: hdl/turret_top.sv
/*
 * Turret top
 * Camera tracking pipeline from sensor pins to the pan and tilt
 * servo outputs.
 */
`timescale 1ns/1ps

module turret_top (
    input  logic                    D5M_PIXLCLK,
    input  logic                    reset,
    input  tracker_pkg::pix_t       D5M_D,
    input  logic                    D5M_LVAL,
    input  logic                    D5M_FVAL,
    input  logic                    capture_start,
    input  logic                    capture_stop,
    output tracker_pkg::centroid_s  centroid,
    output logic                    cent_valid,
    output logic                    on_screen,
    output tracker_pkg::aim_s       aim,
    output logic                    pan_pwm,
    output logic                    tilt_pwm,
    output tracker_pkg::frame_cnt_t frame_count
);

    tracker_pkg::pixel_bus_s pixel;
    tracker_pkg::hit_s       hit;
    logic                    frame_end;

    // ==================================================================
    // Tracking pipeline
    // ==================================================================
    frame_capture u_capture (
        .reset         (reset),
        .D5M_PIXLCLK   (D5M_PIXLCLK),
        .d5m_d         (D5M_D),
        .d5m_lval      (D5M_LVAL),
        .d5m_fval      (D5M_FVAL),
        .capture_start (capture_start),
        .capture_stop  (capture_stop),
        .pixel         (pixel),
        .frame_end     (frame_end),
        .frame_count   (frame_count)
    );

    object_detect u_detect (
        .reset       (reset),
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .pixel       (pixel),
        .hit         (hit)
    );

    centroid_accum u_centroid (
        .reset       (reset),
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .hit         (hit),
        .frame_end   (frame_end),
        .centroid    (centroid),
        .cent_valid  (cent_valid)
    );

    target_hold u_hold (
        .reset       (reset),
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .centroid    (centroid),
        .cent_valid  (cent_valid),
        .aim         (aim),
        .on_screen   (on_screen)
    );

    // Servos, pan follows column and tilt follows row
    servo_pwm u_pan (
        .reset       (reset),
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .position    (aim.col),
        .pwm         (pan_pwm)
    );

    servo_pwm u_tilt (
        .reset       (reset),
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .position    (tracker_pkg::col_t'(aim.row)),
        .pwm         (tilt_pwm)
    );

endmodule

// File: bench/tb_turret.sv
/*
 * Turret tracker testbench
 * Builds camera frames from the golden table, drives them into the
 * tracking pipeline and checks centroid, hold state, aim and servo pulses.
 */
`timescale 1ns/1ps

module tb_turret;

    localparam int NUM_FRAMES   = 11;
    localparam int FIELDS       = 9;
    localparam int LEAD_BLANK   = 4;
    localparam int LINE_BLANK   = 4;
    localparam int DIV_WAIT     = 64;
    localparam int SETTLE       = 2 * tracker_pkg::SERVO_PERIOD + 16;
    localparam int FRAME_CYCLES = LEAD_BLANK + DIV_WAIT + SETTLE +
        tracker_pkg::FRAME_ROWS * (tracker_pkg::FRAME_COLS + LINE_BLANK);
    localparam int CYCLE_LIMIT  = NUM_FRAMES * FRAME_CYCLES + tracker_pkg::SERVO_PERIOD + 1000;

    logic                    D5M_PIXLCLK;
    logic                    reset;
    tracker_pkg::pix_t       d5m_d;
    logic                    d5m_lval;
    logic                    d5m_fval;
    logic                    capture_start;
    logic                    capture_stop;
    tracker_pkg::centroid_s  centroid;
    logic                    cent_valid;
    logic                    on_screen;
    tracker_pkg::aim_s       aim;
    logic                    pan_pwm;
    logic                    tilt_pwm;
    tracker_pkg::frame_cnt_t frame_count;

    logic [15:0]            golden [0:NUM_FRAMES*FIELDS-1];
    logic [31:0]            lcg_state;
    tracker_pkg::centroid_s cv_cent;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int cv_count = 0;
    int pan_run = 0;
    int tilt_run = 0;
    int pan_width = 0;
    int tilt_width = 0;
    int exp_on;
    int misses;
    int tgt_col;
    int tgt_row;
    int enabled_frames;

    turret_top uut (
        .D5M_PIXLCLK   (D5M_PIXLCLK),
        .reset         (reset),
        .D5M_D         (d5m_d),
        .D5M_LVAL      (d5m_lval),
        .D5M_FVAL      (d5m_fval),
        .capture_start (capture_start),
        .capture_stop  (capture_stop),
        .centroid      (centroid),
        .cent_valid    (cent_valid),
        .on_screen     (on_screen),
        .aim           (aim),
        .pan_pwm       (pan_pwm),
        .tilt_pwm      (tilt_pwm),
        .frame_count   (frame_count)
    );

    initial D5M_PIXLCLK = 1'b0;
    always #100 D5M_PIXLCLK = ~D5M_PIXLCLK;

    // ==================================================================
    // Output monitors, sampled mid-cycle
    // ==================================================================
    always @(negedge D5M_PIXLCLK)
    begin
        if (cent_valid)
        begin
            cv_count = cv_count + 1;
            cv_cent  = centroid;
        end
        // High time of the last finished servo pulse
        if (pan_pwm)
            pan_run = pan_run + 1;
        else if (pan_run != 0)
        begin
            pan_width = pan_run;
            pan_run   = 0;
        end
        if (tilt_pwm)
            tilt_run = tilt_run + 1;
        else if (tilt_run != 0)
        begin
            tilt_width = tilt_run;
            tilt_run   = 0;
        end
    end

    always @(posedge D5M_PIXLCLK)
    begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int field(input int k, input int f);
        return int'(golden[k*FIELDS+f]);
    endfunction

    task automatic check_value(input string name, input int actual, input int expected);
        checks = checks + 1;
        if (actual != expected)
        begin
            errors = errors + 1;
            $display("Mismatch at %0t: %s actual %0d expected %0d",
                     $time, name, actual, expected);
        end
    endtask

    task automatic next_cycle();
        @(posedge D5M_PIXLCLK);
        #1;
    endtask

    // ==================================================================
    // Frame generation
    // ==================================================================
    task automatic send_frame(input int k);
        logic in_box;
        d5m_fval = 1'b1;
        repeat (LEAD_BLANK) next_cycle();
        // Enable changes for the next frame are armed inside this one
        if (k + 1 < NUM_FRAMES && field(k + 1, 5) != field(k, 5))
        begin
            if (field(k + 1, 5) != 0)
                capture_start = 1'b1;
            else
                capture_stop = 1'b1;
        end
        for (int r = 0; r < tracker_pkg::FRAME_ROWS; r++)
        begin
            for (int c = 0; c < tracker_pkg::FRAME_COLS; c++)
            begin
                in_box = (c >= field(k, 0)) && (c <= field(k, 1)) &&
                         (r >= field(k, 2)) && (r <= field(k, 3));
                d5m_lval = 1'b1;
                if (in_box)
                    d5m_d = 12'd3000;
                else if (field(k, 4) != 0)
                begin
                    lcg_state = lcg_next(lcg_state);
                    d5m_d     = {1'b0, lcg_state[22:12]};
                end
                else
                    d5m_d = '0;
                next_cycle();
                capture_start = 1'b0;
                capture_stop  = 1'b0;
            end
            d5m_lval = 1'b0;
            d5m_d    = '0;
            repeat (LINE_BLANK) next_cycle();
        end
        d5m_fval = 1'b0;
    endtask

    task automatic finish_frame(input int k, input int cv_before);
        int waited;
        int exp_col;
        int exp_row;
        waited = 0;
        if (field(k, 5) != 0)
        begin
            while (cv_count == cv_before && waited < DIV_WAIT)
            begin
                next_cycle();
                waited = waited + 1;
            end
            enabled_frames = enabled_frames + 1;
            if (cv_count == cv_before)
            begin
                errors = errors + 1;
                $display("Frame %0d: no centroid was reported after the frame ended", k);
            end
            else
            begin
                check_value("centroid.found", int'(cv_cent.found), field(k, 8));
                if (field(k, 8) != 0)
                begin
                    check_value("centroid.col", int'(cv_cent.col), field(k, 6));
                    check_value("centroid.row", int'(cv_cent.row), field(k, 7));
                end
            end
            // Reference hold model
            if (field(k, 8) != 0)
            begin
                tgt_col = field(k, 6);
                tgt_row = field(k, 7);
                exp_on  = 1;
                misses  = 0;
            end
            else
            begin
                misses = misses + 1;
                if (misses >= tracker_pkg::LOST_FRAMES)
                    exp_on = 0;
            end
        end
        else
        begin
            repeat (DIV_WAIT) next_cycle();
            if (cv_count != cv_before)
            begin
                errors = errors + 1;
                $display("Frame %0d: a centroid was reported while capture was stopped", k);
            end
        end
        // Two servo periods so the last pulse reflects the new aim
        repeat (SETTLE) next_cycle();
        exp_col = exp_on ? tgt_col : tracker_pkg::CENTER_COL;
        exp_row = exp_on ? tgt_row : tracker_pkg::CENTER_ROW;
        check_value("on_screen", int'(on_screen), exp_on);
        check_value("aim.col", int'(aim.col), exp_col);
        check_value("aim.row", int'(aim.row), exp_row);
        check_value("pan_pwm high time", pan_width, tracker_pkg::SERVO_MIN + exp_col);
        check_value("tilt_pwm high time", tilt_width, tracker_pkg::SERVO_MIN + exp_row);
        check_value("frame_count", int'(frame_count), enabled_frames);
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial
    begin
        reset          = 1'b1;
        d5m_d          = '0;
        d5m_lval       = 1'b0;
        d5m_fval       = 1'b0;
        capture_start  = 1'b0;
        capture_stop   = 1'b0;
        lcg_state      = 32'h1c4f_5607;
        exp_on         = 0;
        misses         = 0;
        tgt_col        = 0;
        tgt_row        = 0;
        enabled_frames = 0;
        $readmemh("bench/golden_frames.txt", golden);
        repeat (3) next_cycle();
        reset = 1'b0;
        next_cycle();
        if (field(0, 5) != 0)
        begin
            capture_start = 1'b1;
            next_cycle();
            capture_start = 1'b0;
        end
        for (int k = 0; k < NUM_FRAMES; k++)
        begin
            int cv_before;
            cv_before = cv_count;
            send_frame(k);
            finish_frame(k, cv_before);
        end
        check_value("final frame_count", int'(frame_count), enabled_frames);
        $display("Run complete: %0d errors in %0d checks", errors, checks);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: bench/golden_frames.txt
// left right top bottom noise enabled | expected col row found (all hex)
// left above right marks a frame with no target box
0A 13 05 0E 0 1 0E 09 1
28 32 1E 28 1 1 2D 23 1
3F 00 2F 00 1 1 00 00 0
3F 00 2F 00 1 1 00 00 0
00 3F 00 2F 0 1 1F 17 1
3F 00 2F 00 1 1 00 00 0
3F 00 2F 00 1 1 00 00 0
3F 00 2F 00 1 1 00 00 0
14 15 02 03 0 0 00 00 0
32 3C 28 2F 1 0 00 00 0
3C 3F 2C 2F 0 1 3D 2D 1

// File: flist.f
hdl/tracker_pkg.sv
hdl/frame_capture.sv
hdl/object_detect.sv
hdl/centroid_accum.sv
hdl/target_hold.sv
hdl/servo_pwm.sv
hdl/turret_top.sv
bench/tb_turret.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the turret tracker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_turret -f flist.f -o tb_turret_sim

output=$(./obj_dir/tb_turret_sim)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
